/* bench/cart_probe_props.sv */
`timescale 1ns/10ps

module cart_probe_props import cart_probe_pkg::*; (
	input logic  cpuclk,
	input logic  f_reset,
	input byte_t set_mask,
	input byte_t reset_mask,
	input byte_t pa_out
);

	a_reset_clear: assert property (@(posedge cpuclk) f_reset |=> pa_out == '0)
		else $error("pa_out not zero after reset");

	// Set bits show on the next cycle
	a_set_rise: assert property (@(posedge cpuclk) disable iff (f_reset)
		|(set_mask & ~reset_mask) |=>
		(pa_out & $past(set_mask & ~reset_mask)) == $past(set_mask & ~reset_mask))
		else $error("pa_out set bits did not rise");

	// Same bit set and reset
	a_reset_wins: assert property (@(posedge cpuclk) disable iff (f_reset)
		|(set_mask & reset_mask) |=> (pa_out & $past(set_mask & reset_mask)) == '0)
		else $error("pa_out set won over reset");

endmodule

bind port_a cart_probe_props i_props (
	.cpuclk     (cpuclk),
	.f_reset    (f_reset),
	.set_mask   (set_mask),
	.reset_mask (reset_mask),
	.pa_out     (pa_out)
);

/* bench/tb_cart_model.svh */
`ifndef TB_CART_MODEL_SVH
`define TB_CART_MODEL_SVH

// Model state updated as each operation is issued
byte_t  rom_img [1 << `CP_MEM_ADR_W];
byte_t  cap_img [1 << `CP_MEM_ADR_W];
atom_t  m_atom;
byte_t  m_pa;
route_t m_trig_set;
route_t m_trig_reset;
route_t m_trig_cmp;
route_t m_ones;
route_t m_flags;
route_t m_enable;

function automatic logic in_window(logic cs_xram, logic [`CP_DUT_ADR_W-1:0] a);
	return cs_xram && a[13] && !a[14];
endfunction

// Bit 0 also follows the routes and reset beats set
function automatic byte_t pa_next(byte_t pa, byte_t set, byte_t rst, route_t route);
	byte_t res;
	res = pa | set;
	if (|(route & m_trig_set))
		res[0] = 1'b1;
	res = res & ~rst;
	if (|(route & m_trig_reset))
		res[0] = 1'b0;
	return res;
endfunction

// A live route wins over write-1-clear
function automatic route_t flags_next(route_t flags, route_t clr, route_t route);
	route_t res;
	res = flags;
	for (int i = 0; i < `CP_NUM_ROUTES; i++) begin
		if (route[i])
			res[i] = 1'b1;
		else if (clr[i])
			res[i] = 1'b0;
	end
	return res;
endfunction

function automatic byte_t exp_read(host_adr_t a);
	if ((a & 16'hf000) == `CP_BASE_ROM)
		return cap_img[a[`CP_MEM_ADR_W-1:0]];
	if (a >= `CP_ATOM && a <= `CP_ATOM + 16'd3)
		return m_atom[(a - `CP_ATOM) * 8 +: 8];
	case (a)
		`CP_PA:         return m_pa;
		`CP_PA + 16'd1: return pa_in;
		`CP_PA + 16'd2: return byte_t'(m_trig_set);
		`CP_PA + 16'd3: return byte_t'(m_trig_reset);
		`CP_IF:         return byte_t'(m_flags);
		`CP_IE:         return byte_t'(m_enable);
		default:        return 8'hff;
	endcase
endfunction

`endif

/* bench/tb_cart_probe.sv */
`timescale 1ns/10ps
`include "cart_probe_macros.svh"

module tb_cart_probe import cart_probe_pkg::*; ();

	localparam int n_rom = 16;
	localparam int n_cap = 8;
	localparam int n_pa  = 8;
	// Host and DUT operations over all test groups
	localparam int num_ops = 2 * n_rom + 4 * n_cap + 3 * n_pa + 80;

	localparam int sig_rdata = 0;
	localparam int sig_dout  = 1;
	localparam int sig_oe    = 2;
	localparam int sig_pa    = 3;
	localparam int sig_irq   = 4;

	logic                     cpuclk;
	logic                     f_reset;
	host_adr_t                adr;
	byte_t                    wdata;
	logic                     wr;
	logic                     rd;
	byte_t                    rdata;
	logic [`CP_DUT_ADR_W-1:0] dut_adr;
	byte_t                    dut_data_in;
	byte_t                    dut_data_out;
	logic                     dut_data_oe;
	logic                     n_dut_rd;
	logic                     n_dut_wr;
	logic                     n_dut_cs_rom;
	logic                     n_dut_cs_xram;
	byte_t                    pa_in;
	byte_t                    pa_out;
	logic                     irq;

	integer seed;
	int     cyc;
	int     n_checks;
	int     n_errors;
	// Pending expectations by due cycle
	int     q_due [$];
	int     q_sig [$];
	byte_t  q_exp [$];

	`include "tb_cart_model.svh"

	cart_probe_top i_dut (.*);

	initial begin
		cpuclk = 1'b0;
		forever #50 cpuclk = ~cpuclk;
	end

	always @(posedge cpuclk)
		cyc <= cyc + 1;

	// ##############################
	// Stimulus tasks
	// ##############################
	task automatic expect_at(int delay, int sig, byte_t val);
		q_due.push_back(cyc + delay);
		q_sig.push_back(sig);
		q_exp.push_back(val);
	endtask

	task automatic idle(int n);
		repeat (n) @(negedge cpuclk);
	endtask

	task automatic host_write(host_adr_t a, byte_t d);
		adr   = a;
		wdata = d;
		wr    = 1'b1;
		@(negedge cpuclk);
		wr = 1'b0;
	endtask

	task automatic host_read(host_adr_t a);
		adr = a;
		rd  = 1'b1;
		expect_at(1, sig_rdata, exp_read(a));
		@(negedge cpuclk);
		rd = 1'b0;
	endtask

	task automatic load_atom(atom_t v);
		for (int i = 0; i < 4; i++)
			host_write(`CP_ATOM + 16'(i), v[i*8 +: 8]);
		m_atom = v;
	endtask

	task automatic dut_access(logic r, logic w, logic cs_rom, logic cs_xram,
		logic [`CP_DUT_ADR_W-1:0] a, byte_t d);
		logic oe;
		oe = r && (cs_rom || in_window(cs_xram, a));
		expect_at(1, sig_oe, byte_t'(oe));
		if (oe)
			expect_at(1, sig_dout, rom_img[a[`CP_MEM_ADR_W-1:0]]);
		if (w && in_window(cs_xram, a))
			cap_img[a[`CP_MEM_ADR_W-1:0]] = d;
		dut_adr       = a;
		dut_data_in   = d;
		n_dut_rd      = !r;
		n_dut_wr      = !w;
		n_dut_cs_rom  = !cs_rom;
		n_dut_cs_xram = !cs_xram;
		@(negedge cpuclk);
		n_dut_rd      = 1'b1;
		n_dut_wr      = 1'b1;
		n_dut_cs_rom  = 1'b1;
		n_dut_cs_xram = 1'b1;
	endtask

	initial begin : stimulus
		byte_t                    d;
		mem_idx_t                 idx;
		logic [`CP_DUT_ADR_W-1:0] a;
		dut_word_t                cmp;
		dut_word_t                mask;
		seed     = 20;
		cyc      = 0;
		n_checks = 0;
		n_errors = 0;
		f_reset  = 1'b1;
		adr      = '0;
		wdata    = '0;
		wr       = 1'b0;
		rd       = 1'b0;
		dut_adr  = '0;
		dut_data_in   = '0;
		n_dut_rd      = 1'b1;
		n_dut_wr      = 1'b1;
		n_dut_cs_rom  = 1'b1;
		n_dut_cs_xram = 1'b1;
		pa_in    = '0;
		m_pa     = '0;
		m_trig_set   = '0;
		m_trig_reset = '0;
		m_trig_cmp   = '0;
		m_ones   = '0;
		m_flags  = '0;
		m_enable = '0;
		repeat (5) @(negedge cpuclk);
		f_reset = 1'b0;
		expect_at(1, sig_pa, 8'h00);
		expect_at(1, sig_irq, 8'h00);
		expect_at(1, sig_oe, 8'h00);

		// Atomic register then unmapped reads
		load_atom($random(seed));
		for (int i = 0; i < 4; i++)
			host_read(`CP_ATOM + 16'(i));
		host_read(16'h8000);
		host_read(16'hff20);

		// ##############################
		// ROM image and capture
		// ##############################
		for (int i = 0; i < n_rom; i++) begin
			d = $random(seed);
			rom_img[i] = d;
			host_write(`CP_BASE_ROM + 16'(i), d);
		end
		for (int i = 0; i < n_rom; i++) begin
			a = $random(seed);
			a[`CP_MEM_ADR_W-1:0] = mem_idx_t'(i);
			dut_access(1'b1, 1'b0, 1'b1, 1'b0, a, 8'h00);
		end
		for (int i = 0; i < 4; i++)
			dut_access(1'b1, 1'b0, 1'b0, 1'b0, 15'(i), 8'h00);
		for (int i = 0; i < n_cap; i++) begin
			idx = 12'h800 + 12'(i * 5);
			d = $random(seed);
			dut_access(1'b0, 1'b1, 1'b0, 1'b1, {2'b01, 1'b1, idx}, d);
			// Same index outside the window
			dut_access(1'b0, 1'b1, 1'b0, 1'b1, {2'b11, 1'b0, idx}, ~d);
			dut_access(1'b0, 1'b1, 1'b1, 1'b0, {2'b01, 1'b0, idx}, ~d);
		end
		for (int i = 0; i < n_cap; i++)
			host_read(`CP_BASE_ROM + 16'(12'h800 + 12'(i * 5)));

		// Port A set and reset
		for (int i = 0; i < n_pa; i++) begin
			d = $random(seed);
			if (i % 2 == 0)
				m_pa = pa_next(m_pa, d, 8'h00, m_ones);
			else
				m_pa = pa_next(m_pa, 8'h00, d, m_ones);
			expect_at(1, sig_pa, m_pa);
			host_write(`CP_PA + 16'(i % 2), d);
			pa_in = $random(seed);
			host_read(`CP_PA);
			host_read(`CP_PA + 16'd1);
		end

		// ##############################
		// Comparator routes
		// ##############################
		idx = $random(seed);
		d   = $random(seed);
		cmp.rd      = 1'b0;
		cmp.wr      = 1'b1;
		cmp.cs_rom  = 1'b0;
		cmp.cs_xram = 1'b1;
		cmp.data    = d;
		cmp.adr     = {2'b01, 1'b0, idx};
		mask        = '1;
		mask.data   = 8'h00;
		load_atom(atom_t'(cmp));
		host_write(`CP_DUT + 16'd3, 8'h01);
		load_atom(atom_t'(mask));
		host_write(`CP_DUT + 16'd3, 8'h02);
		load_atom(32'h4);
		m_trig_cmp = 4'h4;
		m_trig_set = 4'h4;
		host_write(`CP_DUT + 16'd1, 8'h01);
		host_write(`CP_PA + 16'd2, 8'h01);
		host_read(`CP_PA + 16'd2);
		m_pa = pa_next(m_pa, 8'h00, 8'h01, m_ones);
		expect_at(1, sig_pa, m_pa);
		host_write(`CP_PA + 16'd1, 8'h01);
		// Address off by one
		expect_at(2, sig_pa, m_pa);
		dut_access(1'b0, 1'b1, 1'b0, 1'b1, cmp.adr ^ 15'd1, d);
		idle(1);
		host_read(`CP_IF);
		// Match with data differing only in masked-out bits
		m_flags = flags_next(m_flags, '0, m_ones | m_trig_cmp);
		m_pa    = pa_next(m_pa, 8'h00, 8'h00, m_ones | m_trig_cmp);
		expect_at(2, sig_pa, m_pa);
		expect_at(2, sig_irq, 8'h00);
		dut_access(1'b0, 1'b1, 1'b0, 1'b1, cmp.adr, ~d);
		idle(1);
		host_read(`CP_IF);
		m_enable = m_trig_cmp;
		expect_at(1, sig_irq, 8'h01);
		host_write(`CP_IE, 8'h04);
		host_read(`CP_IE);
		m_flags = flags_next(m_flags, 4'hf, m_ones);
		expect_at(1, sig_irq, 8'h00);
		host_write(`CP_IF, 8'h0f);
		host_read(`CP_IF);

		// Always-one route holds its flags
		load_atom(32'h9);
		m_ones = 4'h9;
		host_write(`CP_ONES_SET, 8'h00);
		idle(1);
		m_flags = flags_next(m_flags, '0, m_ones);
		host_read(`CP_IF);
		m_flags = flags_next(m_flags, 4'hf, m_ones);
		host_write(`CP_IF, 8'h0f);
		host_read(`CP_IF);

		// Route reset against a direct set of bit 0
		load_atom(32'h1);
		m_trig_reset = 4'h1;
		host_write(`CP_PA + 16'd3, 8'h01);
		m_pa = pa_next(m_pa, 8'h01, 8'h00, m_ones);
		expect_at(1, sig_pa, m_pa);
		host_write(`CP_PA, 8'h01);
		host_read(`CP_PA);

		load_atom(32'h0);
		m_ones = '0;
		host_write(`CP_ONES_SET, 8'h00);
		m_flags = flags_next(m_flags, 4'hf, m_ones);
		host_write(`CP_IF, 8'h0f);
		host_read(`CP_IF);

		idle(3);
		if (q_due.size() != 0) begin
			n_errors++;
			$display("%0d expected values were never compared", q_due.size());
		end
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Outputs sampled on the falling edge away from updates
	function automatic byte_t sampled(int sig);
		case (sig)
			sig_rdata: return rdata;
			sig_dout:  return dut_data_out;
			sig_oe:    return byte_t'(dut_data_oe);
			sig_pa:    return pa_out;
			default:   return byte_t'(irq);
		endcase
	endfunction

	function automatic string sig_name(int sig);
		case (sig)
			sig_rdata: return "rdata";
			sig_dout:  return "dut_data_out";
			sig_oe:    return "dut_data_oe";
			sig_pa:    return "pa_out";
			default:   return "irq";
		endcase
	endfunction

	always @(negedge cpuclk) begin : compare
		int    i;
		byte_t act;
		i = 0;
		while (i < q_due.size()) begin
			if (q_due[i] == cyc) begin
				act = sampled(q_sig[i]);
				n_checks++;
				if (act !== q_exp[i]) begin
					n_errors++;
					$display("error at %0t: %s is %h, expected %h", $time,
						sig_name(q_sig[i]), act, q_exp[i]);
				end
				q_due.delete(i);
				q_sig.delete(i);
				q_exp.delete(i);
			end else begin
				i++;
			end
		end
	end

	initial begin : watchdog
		repeat (num_ops * 20) @(posedge cpuclk);
		$display("timeout: stimulus did not finish within %0d cycles", num_ops * 20);
		$display("Checks failed");
		$finish;
	end

endmodule

/* cart_emu/cart_mem.sv */
`timescale 1ns/10ps
`include "cart_probe_macros.svh"

module cart_mem import cart_probe_pkg::*; (
	input  logic      cpuclk,
	host_bus_if.dev   bus,
	input  dut_word_t dut,
	output byte_t     dut_data_out,
	output logic      dut_data_oe,
	output byte_t     mem_rdata
);

	localparam int mem_depth = 1 << `CP_MEM_ADR_W;

	byte_t    rom_mem [mem_depth];
	byte_t    cap_mem [mem_depth];
	mem_idx_t dut_idx;
	logic     dut_window;
	logic     dut_any_cs;

	assign dut_idx    = mem_idx_t'(dut.adr[`CP_MEM_ADR_W-1:0]);
	assign dut_window = dut.cs_xram && dut.adr[13] && !dut.adr[14];
	assign dut_any_cs = dut.cs_rom || dut_window;

	// ##############################
	// Host side
	// ##############################
	always_ff @(posedge cpuclk) begin
		if (bus.wr && bus.sel == sel_mem)
			rom_mem[bus.idx] <= bus.wdata;
		// Host sees what the DUT wrote
		if (bus.rd && bus.sel == sel_mem)
			mem_rdata <= cap_mem[bus.idx];
	end

	// ##############################
	// DUT side
	// ##############################
	always_ff @(posedge cpuclk) begin
		dut_data_out <= rom_mem[dut_idx];
		dut_data_oe  <= dut.rd && dut_any_cs;
		if (dut.wr && dut_window)
			cap_mem[dut_idx] <= dut.data;
	end

endmodule

/* cart_emu/dut_monitor.sv */
`timescale 1ns/10ps
`include "cart_probe_macros.svh"

module dut_monitor import cart_probe_pkg::*; (
	input  logic      cpuclk,
	input  logic      f_reset,
	host_bus_if.dev   bus,
	input  dut_word_t dut,
	output byte_t     dut_rdata,
	output route_t    cmp_route
);

	localparam int word_w = $bits(dut_word_t);

	dut_word_t   snap;
	dut_word_t   cmp_val;
	dut_word_t   cmp_mask;
	route_t      trig;
	logic [31:0] snap_word;
	logic        dut_wr;
	logic        match;

	// Bus sample, one cycle behind the pins
	always_ff @(posedge cpuclk) begin
		snap <= dut;
	end

	assign dut_wr = bus.wr && bus.sel == sel_dut;

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			cmp_val  <= '0;
			cmp_mask <= '0;
			trig     <= '0;
		end else begin
			if (dut_wr && bus.sub == 2'd3 && bus.wdata[0])
				cmp_val <= dut_word_t'(bus.atom[word_w-1:0]);
			if (dut_wr && bus.sub == 2'd3 && bus.wdata[1])
				cmp_mask <= dut_word_t'(bus.atom[word_w-1:0]);
			if (dut_wr && bus.sub == 2'd1 && bus.wdata[0])
				trig <= bus.atom[`CP_NUM_ROUTES-1:0];
		end
	end

	// ##############################
	// Masked comparator
	// ##############################
	assign match     = ((snap ^ cmp_val) & cmp_mask) == '0;
	assign cmp_route = match ? trig : '0;

	// Snapshot bytes, lowest first
	assign snap_word = 32'(snap);

	always_ff @(posedge cpuclk) begin
		if (bus.rd && bus.sel == sel_dut)
			dut_rdata <= snap_word[bus.sub*8 +: 8];
	end

endmodule

/* common/cart_probe_macros.svh */
`ifndef CART_PROBE_MACROS_SVH
`define CART_PROBE_MACROS_SVH

// Sizes
`define CP_NUM_ROUTES 4
`define CP_MEM_ADR_W  12
`define CP_DUT_ADR_W  15
`define CP_ATOM_W     32

// ##############################
// Host address map
// ##############################
`define CP_BASE_ROM 16'h1000
`define CP_ATOM     16'hff10
`define CP_ONES_SET 16'hff14
`define CP_PA       16'hff40
`define CP_DUT      16'hff50
`define CP_IF       16'hfffe
`define CP_IE       16'hffff

`endif

/* common/cart_probe_pkg.sv */
`include "cart_probe_macros.svh"

package cart_probe_pkg;

	typedef logic [7:0] byte_t;

	typedef logic [15:0] host_adr_t;

	// One bit per trigger route
	typedef logic [`CP_NUM_ROUTES-1:0] route_t;

	typedef logic [`CP_ATOM_W-1:0] atom_t;

	typedef logic [`CP_MEM_ADR_W-1:0] mem_idx_t;

	// Decoded host targets
	typedef enum logic [2:0] {
		sel_none,
		sel_mem,
		sel_atom,
		sel_ones_set,
		sel_port_a,
		sel_dut,
		sel_irq_if,
		sel_irq_ie
	} host_sel_t;

	// One DUT bus sample, adr in the low bits
	typedef struct packed {
		logic                     rd;
		logic                     wr;
		logic                     cs_rom;
		logic                     cs_xram;
		logic [7:0]               data;
		logic [`CP_DUT_ADR_W-1:0] adr;
	} dut_word_t;

endpackage

/* common/host_bus_if.sv */
`timescale 1ns/10ps

interface host_bus_if import cart_probe_pkg::*; ();

	host_sel_t  sel;
	logic [1:0] sub;
	mem_idx_t   idx;
	byte_t      wdata;
	logic       wr;
	logic       rd;
	atom_t      atom;

	// Decoder side
	modport ctrl (
		output sel, sub, idx, wdata, wr, rd, atom
	);

	// Device side
	modport dev (
		input sel, sub, idx, wdata, wr, rd, atom
	);

endinterface

/* verilog/cart_probe_top.sv */
`timescale 1ns/10ps
`include "cart_probe_macros.svh"

module cart_probe_top import cart_probe_pkg::*; (
	input  logic                     cpuclk,
	input  logic                     f_reset,
	input  host_adr_t                adr,
	input  byte_t                    wdata,
	input  logic                     wr,
	input  logic                     rd,
	output byte_t                    rdata,
	input  logic [`CP_DUT_ADR_W-1:0] dut_adr,
	input  byte_t                    dut_data_in,
	output byte_t                    dut_data_out,
	output logic                     dut_data_oe,
	input  logic                     n_dut_rd,
	input  logic                     n_dut_wr,
	input  logic                     n_dut_cs_rom,
	input  logic                     n_dut_cs_xram,
	input  byte_t                    pa_in,
	output byte_t                    pa_out,
	output logic                     irq
);

	host_bus_if bus ();

	dut_word_t dut;
	byte_t     mem_rdata;
	byte_t     pa_rdata;
	byte_t     dut_rdata;
	byte_t     irq_rdata;
	route_t    cmp_route;
	route_t    route;

	// DUT strobes are active low on the pins
	assign dut.rd      = !n_dut_rd;
	assign dut.wr      = !n_dut_wr;
	assign dut.cs_rom  = !n_dut_cs_rom;
	assign dut.cs_xram = !n_dut_cs_xram;
	assign dut.data    = dut_data_in;
	assign dut.adr     = dut_adr;

	host_bus_ctrl i_ctrl (
		.cpuclk    (cpuclk),
		.f_reset   (f_reset),
		.adr       (adr),
		.wdata     (wdata),
		.wr        (wr),
		.rd        (rd),
		.bus       (bus.ctrl),
		.mem_rdata (mem_rdata),
		.pa_rdata  (pa_rdata),
		.dut_rdata (dut_rdata),
		.irq_rdata (irq_rdata),
		.rdata     (rdata)
	);

	cart_mem i_mem (
		.cpuclk       (cpuclk),
		.bus          (bus.dev),
		.dut          (dut),
		.dut_data_out (dut_data_out),
		.dut_data_oe  (dut_data_oe),
		.mem_rdata    (mem_rdata)
	);

	dut_monitor i_mon (
		.cpuclk    (cpuclk),
		.f_reset   (f_reset),
		.bus       (bus.dev),
		.dut       (dut),
		.dut_rdata (dut_rdata),
		.cmp_route (cmp_route)
	);

	route_hub i_hub (
		.cpuclk    (cpuclk),
		.f_reset   (f_reset),
		.bus       (bus.dev),
		.cmp_route (cmp_route),
		.route     (route),
		.irq_rdata (irq_rdata),
		.irq       (irq)
	);

	port_a i_pa (
		.cpuclk   (cpuclk),
		.f_reset  (f_reset),
		.bus      (bus.dev),
		.route    (route),
		.pa_in    (pa_in),
		.pa_out   (pa_out),
		.pa_rdata (pa_rdata)
	);

endmodule

/* verilog/host_bus_ctrl.sv */
`timescale 1ns/10ps
`include "cart_probe_macros.svh"

module host_bus_ctrl import cart_probe_pkg::*; (
	input  logic       cpuclk,
	input  logic       f_reset,
	input  host_adr_t  adr,
	input  byte_t      wdata,
	input  logic       wr,
	input  logic       rd,
	host_bus_if.ctrl   bus,
	input  byte_t      mem_rdata,
	input  byte_t      pa_rdata,
	input  byte_t      dut_rdata,
	input  byte_t      irq_rdata,
	output byte_t      rdata
);

	localparam host_adr_t adr_rom      = `CP_BASE_ROM;
	localparam host_adr_t adr_atom     = `CP_ATOM;
	localparam host_adr_t adr_ones_set = `CP_ONES_SET;
	localparam host_adr_t adr_pa       = `CP_PA;
	localparam host_adr_t adr_dut      = `CP_DUT;
	localparam host_adr_t adr_if       = `CP_IF;
	localparam host_adr_t adr_ie       = `CP_IE;

	host_sel_t  sel;
	host_sel_t  r_sel;
	logic [1:0] r_sub;
	atom_t      atom;

	// ##############################
	// Address decode
	// ##############################
	always_comb begin
		sel = sel_none;
		if (adr[15:12] == adr_rom[15:12])
			sel = sel_mem;
		else if (adr[15:2] == adr_atom[15:2])
			sel = sel_atom;
		else if (adr == adr_ones_set)
			sel = sel_ones_set;
		else if (adr[15:2] == adr_pa[15:2])
			sel = sel_port_a;
		else if (adr[15:2] == adr_dut[15:2])
			sel = sel_dut;
		else if (adr == adr_if)
			sel = sel_irq_if;
		else if (adr == adr_ie)
			sel = sel_irq_ie;
	end

	assign bus.sel   = sel;
	assign bus.sub   = adr[1:0];
	assign bus.idx   = mem_idx_t'(adr[`CP_MEM_ADR_W-1:0]);
	assign bus.wdata = wdata;
	assign bus.wr    = wr;
	assign bus.rd    = rd;
	assign bus.atom  = atom;

	// Atomic load register, one byte per write
	always_ff @(posedge cpuclk) begin
		if (wr && sel == sel_atom)
			atom[adr[1:0]*8 +: 8] <= wdata;
	end

	// Read target held for the data cycle only
	always_ff @(posedge cpuclk) begin
		if (f_reset)
			r_sel <= sel_none;
		else
			r_sel <= rd ? sel : sel_none;
		r_sub <= adr[1:0];
	end

	// ##############################
	// Read data mux
	// ##############################
	always_comb begin
		case (r_sel)
			sel_mem:    rdata = mem_rdata;
			sel_atom:   rdata = atom[r_sub*8 +: 8];
			sel_port_a: rdata = pa_rdata;
			sel_dut:    rdata = dut_rdata;
			sel_irq_if,
			sel_irq_ie: rdata = irq_rdata;
			default:    rdata = 8'hff;
		endcase
	end

endmodule

/* verilog/port_a.sv */
`timescale 1ns/10ps
`include "cart_probe_macros.svh"

module port_a import cart_probe_pkg::*; (
	input  logic     cpuclk,
	input  logic     f_reset,
	host_bus_if.dev  bus,
	input  route_t   route,
	input  byte_t    pa_in,
	output byte_t    pa_out,
	output byte_t    pa_rdata
);

	route_t trig_set;
	route_t trig_reset;
	byte_t  set_mask;
	byte_t  reset_mask;
	logic   pa_wr;

	assign pa_wr = bus.wr && bus.sel == sel_port_a;

	// Direct writes, plus routes on bit 0
	always_comb begin
		set_mask      = (pa_wr && bus.sub == 2'd0) ? bus.wdata : 8'h00;
		reset_mask    = (pa_wr && bus.sub == 2'd1) ? bus.wdata : 8'h00;
		set_mask[0]   = set_mask[0] | (|(trig_set & route));
		reset_mask[0] = reset_mask[0] | (|(trig_reset & route));
	end

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			pa_out     <= '0;
			trig_set   <= '0;
			trig_reset <= '0;
		end else begin
			// Reset beats set
			pa_out <= (pa_out | set_mask) & ~reset_mask;
			if (pa_wr && bus.sub == 2'd2 && bus.wdata == 8'd1)
				trig_set <= bus.atom[`CP_NUM_ROUTES-1:0];
			if (pa_wr && bus.sub == 2'd3 && bus.wdata == 8'd1)
				trig_reset <= bus.atom[`CP_NUM_ROUTES-1:0];
		end
	end

	always_ff @(posedge cpuclk) begin
		if (bus.rd && bus.sel == sel_port_a) begin
			case (bus.sub)
				2'd0:    pa_rdata <= pa_out;
				2'd1:    pa_rdata <= pa_in;
				2'd2:    pa_rdata <= {{(8-`CP_NUM_ROUTES){1'b0}}, trig_set};
				default: pa_rdata <= {{(8-`CP_NUM_ROUTES){1'b0}}, trig_reset};
			endcase
		end
	end

endmodule

/* verilog/route_hub.sv */
`timescale 1ns/10ps
`include "cart_probe_macros.svh"

module route_hub import cart_probe_pkg::*; (
	input  logic     cpuclk,
	input  logic     f_reset,
	host_bus_if.dev  bus,
	input  route_t   cmp_route,
	output route_t   route,
	output byte_t    irq_rdata,
	output logic     irq
);

	route_t ones_set;
	route_t flags;
	route_t enable;
	route_t clr;

	assign route = ones_set | cmp_route;

	// Write-1-clear on IF
	assign clr = (bus.wr && bus.sel == sel_irq_if) ? bus.wdata[`CP_NUM_ROUTES-1:0] : '0;

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			ones_set <= '0;
			flags    <= '0;
			enable   <= '0;
		end else begin
			if (bus.wr && bus.sel == sel_ones_set)
				ones_set <= bus.atom[`CP_NUM_ROUTES-1:0];
			if (bus.wr && bus.sel == sel_irq_ie)
				enable <= bus.wdata[`CP_NUM_ROUTES-1:0];
			// A live route keeps its flag set
			flags <= (flags & ~clr) | route;
		end
	end

	assign irq = |(flags & enable);

	always_ff @(posedge cpuclk) begin
		if (bus.rd && bus.sel == sel_irq_if)
			irq_rdata <= {{(8-`CP_NUM_ROUTES){1'b0}}, flags};
		else if (bus.rd && bus.sel == sel_irq_ie)
			irq_rdata <= {{(8-`CP_NUM_ROUTES){1'b0}}, enable};
	end

endmodule

/* vlog.f */
+incdir+common
+incdir+bench
common/cart_probe_pkg.sv
common/host_bus_if.sv
verilog/host_bus_ctrl.sv
verilog/port_a.sv
verilog/route_hub.sv
cart_emu/cart_mem.sv
cart_emu/dut_monitor.sv
verilog/cart_probe_top.sv
bench/cart_probe_props.sv
bench/tb_cart_probe.sv
